// File: source/sys1_pkg.sv
/*
 * Sega System 1 control package
 * Widths, mode-bit positions, loader indices and the bit maps
 * of the joystick word and the adapter button vector
 */
package sys1_pkg;

	//////////////////////////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////////////////////////

	// Joystick word, one per player
	typedef logic [15:0] joy_word_t;
	// Adapter button vector, buttons low and d-pad high
	typedef logic [31:0] pad_buttons_t;
	// Adapter type, 0 and 255 report no pad
	typedef logic [7:0]  pad_type_t;
	// Active-low game input byte
	typedef logic [7:0]  port_byte_t;
	// Mode or DIP byte
	typedef logic [7:0]  cfg_byte_t;
	// Pixel as RRRGGGBB
	typedef logic [7:0]  rgb8_t;
	typedef logic [24:0] load_addr_t;

	// System mode byte bits
	localparam int MODE_H240       = 2;
	localparam int MODE_DUAL_STICK = 3;
	localparam int MODE_SPINNER    = 5;

	// Loader indices and DIP window
	localparam cfg_byte_t IDX_MODE   = 8'd1;
	localparam cfg_byte_t IDX_DIP    = 8'd254;
	// Eight DIP bytes, so three address bits
	localparam int        DIP_ADDR_W = 3;

	// Adapter type codes with no pad behind them
	localparam pad_type_t PAD_TYPE_NONE  = 8'h00;
	localparam pad_type_t PAD_TYPE_EMPTY = 8'hFF;

	// Joystick word bit map
	localparam int JOY_RIGHT  = 0;
	localparam int JOY_LEFT   = 1;
	localparam int JOY_DOWN   = 2;
	localparam int JOY_UP     = 3;
	localparam int JOY_TRIG1  = 4;
	localparam int JOY_TRIG2  = 5;
	localparam int JOY_TRIG3  = 6;
	localparam int JOY_TRIG4  = 7;
	localparam int JOY_TRIG5  = 8;
	localparam int JOY_START1 = 9;
	localparam int JOY_START2 = 10;
	localparam int JOY_COIN   = 11;
	localparam int JOY_PAUSE  = 12;

	// Adapter vector bits, d-pad first
	localparam int PAD_RIGHT = 24;
	localparam int PAD_LEFT  = 25;
	localparam int PAD_DOWN  = 26;
	localparam int PAD_UP    = 27;
	localparam int PAD_FIRST = 0;
	localparam int PAD_START = 5;
	localparam int PAD_COIN  = 4;

endpackage

// File: source/sys1_config_loader.sv
/*
 * Sega System 1 configuration loader
 * Captures the system mode byte and DIP bytes 0 and 1 from
 * loader writes and exports the mode bits in use
 */
module sys1_config_loader import sys1_pkg::*; (
	input  logic       clk_sys,
	input  logic       iRST,
	input  logic       load_wr,
	input  cfg_byte_t  load_index,
	input  load_addr_t load_addr,
	input  cfg_byte_t  load_data,
	output logic       mode_dual_stick,
	output logic       mode_spinner,
	output logic       h240,
	output cfg_byte_t  dsw0,
	output cfg_byte_t  dsw1
);

	// Full system mode byte as downloaded
	cfg_byte_t mode_reg;

	logic                  mode_hit;
	logic                  dip_hit;
	logic [DIP_ADDR_W-1:0] dip_slot;

	//////////////////////////////////////////////////////////////////////
	// Write decode
	//////////////////////////////////////////////////////////////////////

	// Mode byte lives at address 0 only
	assign mode_hit = (load_index == IDX_MODE) && (load_addr == '0);
	// DIP window is the first eight addresses
	assign dip_hit  = (load_index == IDX_DIP) &&
		(load_addr[$bits(load_addr_t)-1:DIP_ADDR_W] == '0);
	assign dip_slot = load_addr[DIP_ADDR_W-1:0];

	// Registers, new value visible on the next cycle
	always_ff @(posedge clk_sys) begin
		if (iRST) begin
			mode_reg <= '0;
			dsw0     <= '0;
			dsw1     <= '0;
		end else if (load_wr) begin
			if (mode_hit) begin
				mode_reg <= load_data;
			end
			// Slots 2..7 are accepted but not stored
			if (dip_hit && (dip_slot == DIP_ADDR_W'(0))) begin
				dsw0 <= load_data;
			end
			if (dip_hit && (dip_slot == DIP_ADDR_W'(1))) begin
				dsw1 <= load_data;
			end
		end
	end

	// Mode bits used by this design
	assign h240            = mode_reg[MODE_H240];
	assign mode_dual_stick = mode_reg[MODE_DUAL_STICK];
	assign mode_spinner    = mode_reg[MODE_SPINNER];

endmodule

// File: source/sys1_player_select.sv
/*
 * Sega System 1 player source selection
 * Detects adapter pads, maps their buttons into joystick words,
 * merges them with the USB pads and raises the OSD combo
 */
module sys1_player_select import sys1_pkg::*; (
	input  logic         clk_sys,
	input  logic         iRST,
	input  pad_buttons_t pad1_buttons,
	input  pad_buttons_t pad2_buttons,
	input  pad_type_t    pad1_type,
	input  pad_type_t    pad2_type,
	input  logic         pad1_valid,
	input  logic         pad2_valid,
	input  joy_word_t    usb_joy1,
	input  joy_word_t    usb_joy2,
	output joy_word_t    joy1,
	output joy_word_t    joy2,
	output logic         pause_button,
	output logic         osd_request
);

	// Sticky flags, set by the first press on each pad
	logic pad1_seen;
	logic pad2_seen;

	logic      use_pad1;
	logic      use_pad2;
	joy_word_t pad1_joy;
	joy_word_t pad2_joy;

	// Type code says a real pad is there
	function automatic logic type_known(input pad_type_t t);
		return (t != PAD_TYPE_NONE) && (t != PAD_TYPE_EMPTY);
	endfunction

	// Adapter vector to joystick word
	// Start goes to the slot of the player, pause stays clear
	function automatic joy_word_t pad_to_joy(input pad_buttons_t b, input logic second);
		joy_word_t j;
		j             = '0;
		j[JOY_RIGHT]  = b[PAD_RIGHT];
		j[JOY_LEFT]   = b[PAD_LEFT];
		j[JOY_DOWN]   = b[PAD_DOWN];
		j[JOY_UP]     = b[PAD_UP];
		j[JOY_TRIG1]  = b[0];
		j[JOY_TRIG2]  = b[1];
		j[JOY_TRIG3]  = b[2];
		j[JOY_TRIG4]  = b[3];
		j[JOY_TRIG5]  = b[6];
		j[JOY_START1] = b[PAD_START] & ~second;
		j[JOY_START2] = b[PAD_START] & second;
		j[JOY_COIN]   = b[PAD_COIN];
		return j;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Presence detection
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (iRST) begin
			pad1_seen <= 1'b0;
			pad2_seen <= 1'b0;
		end else begin
			if (|pad1_buttons) begin
				pad1_seen <= 1'b1;
			end
			if (|pad2_buttons) begin
				pad2_seen <= 1'b1;
			end
		end
	end

	// Type 0 or 255 counts only once a button was seen
	assign use_pad1 = pad1_valid && (type_known(pad1_type) || pad1_seen);
	assign use_pad2 = pad2_valid && (type_known(pad2_type) || pad2_seen);

	assign pad1_joy = pad_to_joy(pad1_buttons, 1'b0);
	assign pad2_joy = pad_to_joy(pad2_buttons, 1'b1);

	//////////////////////////////////////////////////////////////////////
	// Player merge
	//////////////////////////////////////////////////////////////////////

	// Adapter pads keep their slot, USB pad 1 fills the free one
	always_comb begin
		if (use_pad1 && use_pad2) begin
			joy1 = pad1_joy;
			joy2 = pad2_joy;
		end else if (use_pad1 || use_pad2) begin
			joy1 = use_pad1 ? pad1_joy : usb_joy1;
			joy2 = use_pad2 ? pad2_joy : usb_joy1;
		end else begin
			joy1 = usb_joy1;
			joy2 = usb_joy2;
		end
	end

	// Pause from either player
	assign pause_button = joy1[JOY_PAUSE] | joy2[JOY_PAUSE];

	// Down, start and first button on either adapter
	assign osd_request =
		(pad1_buttons[PAD_DOWN] & pad1_buttons[PAD_START] & pad1_buttons[PAD_FIRST]) |
		(pad2_buttons[PAD_DOWN] & pad2_buttons[PAD_START] & pad2_buttons[PAD_FIRST]);

endmodule

// File: source/sys1_input_encoder.sv
/*
 * Sega System 1 input port encoder
 * Builds the three active-low input bytes for normal,
 * dual-stick and spinner modes, registered once
 */
module sys1_input_encoder import sys1_pkg::*; (
	input  logic       clk_sys,
	input  logic       iRST,
	input  joy_word_t  joy1,
	input  joy_word_t  joy2,
	input  logic       mode_dual_stick,
	input  logic       mode_spinner,
	input  port_byte_t spin_pos,
	output port_byte_t inp0,
	output port_byte_t inp1,
	output port_byte_t inp2
);

	// Right stick of player 1 sits on the trigger bits
	localparam int RSTICK_OFS = 4;

	joy_word_t  joy_any;
	logic [3:0] lstick;
	logic [3:0] rstick;
	port_byte_t inp0_d;
	port_byte_t inp1_d;
	port_byte_t inp2_d;

	assign joy_any = joy1 | joy2;

	// Sticks as right, left, down, up
	assign lstick = joy1[JOY_UP:JOY_RIGHT];
	// Player 2 stick doubles as the right stick
	assign rstick = joy1[JOY_UP+RSTICK_OFS:JOY_RIGHT+RSTICK_OFS] | joy2[JOY_UP:JOY_RIGHT];

	//////////////////////////////////////////////////////////////////////
	// Per-mode byte layout, active high here
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		// Start and coin are common to all modes
		inp2_d = {2'b00, joy_any[JOY_START2], joy_any[JOY_START1], 3'b000, joy_any[JOY_COIN]};
		if (mode_spinner) begin
			// Spinner wins over dual stick
			inp0_d    = spin_pos;
			inp1_d    = spin_pos;
			inp2_d[7] = joy_any[JOY_TRIG1];
			inp2_d[6] = joy_any[JOY_TRIG1];
		end else if (mode_dual_stick) begin
			// Left stick then right stick, left/right/up/down each
			inp0_d = {lstick[JOY_LEFT], lstick[JOY_RIGHT], lstick[JOY_UP], lstick[JOY_DOWN],
				rstick[JOY_LEFT], rstick[JOY_RIGHT], rstick[JOY_UP], rstick[JOY_DOWN]};
			inp1_d    = inp0_d;
			inp2_d[7] = joy1[JOY_TRIG1];
			inp2_d[6] = joy1[JOY_TRIG1];
		end else begin
			// Normal mode, both players share one layout
			inp0_d = {joy_any[JOY_LEFT], joy_any[JOY_RIGHT], joy_any[JOY_UP],
				joy_any[JOY_DOWN], 1'b0, joy_any[JOY_TRIG2], joy_any[JOY_TRIG1],
				joy_any[JOY_TRIG3]};
			inp1_d = inp0_d;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Output registers
	//////////////////////////////////////////////////////////////////////

	// All ones means nothing pressed
	always_ff @(posedge clk_sys) begin
		if (iRST) begin
			inp0 <= '1;
			inp1 <= '1;
			inp2 <= '1;
		end else begin
			inp0 <= ~inp0_d;
			inp1 <= ~inp1_d;
			inp2 <= ~inp2_d;
		end
	end

endmodule

// File: source/sys1_pause_ctrl.sv
/*
 * Sega System 1 pause control
 * Toggles pause from the pause button, pauses on an open OSD
 * and dims the pixel after a long pause
 */
module sys1_pause_ctrl import sys1_pkg::*; #(
	parameter int unsigned DIM_CYCLES = 480000000
) (
	input  logic  clk_sys,
	input  logic  iRST,
	input  logic  pause_button,
	input  logic  osd_open,
	input  logic  pause_on_osd,
	input  rgb8_t rgb_in,
	output logic  pause,
	output rgb8_t rgb_out
);

	// Counter wide enough to hold DIM_CYCLES itself
	localparam int CNT_W = $clog2(DIM_CYCLES + 1);
	localparam logic [CNT_W-1:0] DIM_LAST = CNT_W'(DIM_CYCLES);

	logic             button_q;
	logic             pause_toggle;
	logic [CNT_W-1:0] dim_cnt;
	logic             dim;
	logic [2:0]       red;
	logic [2:0]       green;
	logic [1:0]       blue;

	//////////////////////////////////////////////////////////////////////
	// Toggle and dim timer
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (iRST) begin
			button_q     <= 1'b0;
			pause_toggle <= 1'b0;
			dim_cnt      <= '0;
		end else begin
			button_q <= pause_button;
			// Flip once per press
			if (pause_button && !button_q) begin
				pause_toggle <= ~pause_toggle;
			end
			// Count up while paused and hold at the limit
			if (pause_toggle) begin
				if (dim_cnt < DIM_LAST) begin
					dim_cnt <= dim_cnt + 1'b1;
				end
			end else begin
				dim_cnt <= '0;
			end
		end
	end

	// User pause or open OSD when enabled
	assign pause = pause_toggle | (osd_open & pause_on_osd);

	//////////////////////////////////////////////////////////////////////
	// Pixel dimming
	//////////////////////////////////////////////////////////////////////

	assign dim   = (dim_cnt == DIM_LAST);
	// RRRGGGBB
	assign red   = rgb_in[7:5];
	assign green = rgb_in[4:2];
	assign blue  = rgb_in[1:0];

	// Each field at half level once dimmed
	assign rgb_out = dim ? {red >> 1, green >> 1, blue >> 1} : rgb_in;

endmodule

// File: source/sys1_control_top.sv
/*
 * Sega System 1 player control and configuration
 * Top level joining config download, player selection,
 * input encoding and pause control
 */
module sys1_control_top import sys1_pkg::*; #(
	// Pause cycles before the picture dims
	parameter int unsigned DIM_CYCLES = 480000000
) (
	input  logic         clk_sys,
	input  logic         iRST,

	// Loader write port
	input  logic         load_wr,
	input  cfg_byte_t    load_index,
	input  load_addr_t   load_addr,
	input  cfg_byte_t    load_data,

	// Adapter pads, already decoded
	input  pad_buttons_t pad1_buttons,
	input  pad_type_t    pad1_type,
	input  logic         pad1_valid,
	input  pad_buttons_t pad2_buttons,
	input  pad_type_t    pad2_type,
	input  logic         pad2_valid,

	// USB pads and spinner
	input  joy_word_t    usb_joy1,
	input  joy_word_t    usb_joy2,
	input  port_byte_t   spin_pos,

	// OSD and video
	input  logic         osd_open,
	input  logic         pause_on_osd,
	input  rgb8_t        rgb_in,

	// Game side
	output port_byte_t   inp0,
	output port_byte_t   inp1,
	output port_byte_t   inp2,
	output cfg_byte_t    dsw0,
	output cfg_byte_t    dsw1,
	output logic         h240,
	output logic         pause,
	output rgb8_t        rgb_out,
	output logic         osd_request
);

	logic      mode_dual_stick;
	logic      mode_spinner;
	joy_word_t joy1;
	joy_word_t joy2;
	logic      pause_button;

	//////////////////////////////////////////////////////////////////////
	// Blocks
	//////////////////////////////////////////////////////////////////////

	sys1_config_loader u_config_loader (
		.clk_sys         (clk_sys),
		.iRST            (iRST),
		.load_wr         (load_wr),
		.load_index      (load_index),
		.load_addr       (load_addr),
		.load_data       (load_data),
		.mode_dual_stick (mode_dual_stick),
		.mode_spinner    (mode_spinner),
		.h240            (h240),
		.dsw0            (dsw0),
		.dsw1            (dsw1)
	);

	sys1_player_select u_player_select (
		.clk_sys      (clk_sys),
		.iRST         (iRST),
		.pad1_buttons (pad1_buttons),
		.pad2_buttons (pad2_buttons),
		.pad1_type    (pad1_type),
		.pad2_type    (pad2_type),
		.pad1_valid   (pad1_valid),
		.pad2_valid   (pad2_valid),
		.usb_joy1     (usb_joy1),
		.usb_joy2     (usb_joy2),
		.joy1         (joy1),
		.joy2         (joy2),
		.pause_button (pause_button),
		.osd_request  (osd_request)
	);

	sys1_input_encoder u_input_encoder (
		.clk_sys         (clk_sys),
		.iRST            (iRST),
		.joy1            (joy1),
		.joy2            (joy2),
		.mode_dual_stick (mode_dual_stick),
		.mode_spinner    (mode_spinner),
		.spin_pos        (spin_pos),
		.inp0            (inp0),
		.inp1            (inp1),
		.inp2            (inp2)
	);

	sys1_pause_ctrl #(
		.DIM_CYCLES (DIM_CYCLES)
	) u_pause_ctrl (
		.clk_sys      (clk_sys),
		.iRST         (iRST),
		.pause_button (pause_button),
		.osd_open     (osd_open),
		.pause_on_osd (pause_on_osd),
		.rgb_in       (rgb_in),
		.pause        (pause),
		.rgb_out      (rgb_out)
	);

endmodule

// File: tests/tb_sys1_control.sv
/*
 * Testbench for the Sega System 1 player control top level
 * Replays the golden vectors one clock at a time and checks
 * every output against the expected values of the same line
 */
module tb_sys1_control;

	localparam int CLK_PERIOD = 40;
	// Packed widths of one stimulus line and one expected line
	localparam int STIM_W     = 174;
	localparam int EXP_W      = 51;
	localparam     GOLDEN_PATH = "tests/sys1_golden.txt";

	// DUT inputs
	logic        clk_sys = 1'b0;
	logic        iRST;
	logic        load_wr;
	logic [7:0]  load_index;
	logic [24:0] load_addr;
	logic [7:0]  load_data;
	logic [31:0] pad1_buttons;
	logic [7:0]  pad1_type;
	logic        pad1_valid;
	logic [31:0] pad2_buttons;
	logic [7:0]  pad2_type;
	logic        pad2_valid;
	logic [15:0] usb_joy1;
	logic [15:0] usb_joy2;
	logic [7:0]  spin_pos;
	logic        osd_open;
	logic        pause_on_osd;
	logic [7:0]  rgb_in;

	// DUT outputs
	logic [7:0]  inp0;
	logic [7:0]  inp1;
	logic [7:0]  inp2;
	logic [7:0]  dsw0;
	logic [7:0]  dsw1;
	logic        h240;
	logic        pause;
	logic [7:0]  rgb_out;
	logic        osd_request;

	// Vectors as read from the golden file
	string             name_q[$];
	logic [STIM_W-1:0] stim_q[$];
	logic [EXP_W-1:0]  exp_q[$];

	int unsigned cycle_count = 0;
	int unsigned cycle_limit = 20;

	// Short dim delay so the dimming shows up within a few vectors
	sys1_control_top #(
		.DIM_CYCLES (8)
	) u_sys1_control_top (
		.clk_sys      (clk_sys),
		.iRST         (iRST),
		.load_wr      (load_wr),
		.load_index   (load_index),
		.load_addr    (load_addr),
		.load_data    (load_data),
		.pad1_buttons (pad1_buttons),
		.pad1_type    (pad1_type),
		.pad1_valid   (pad1_valid),
		.pad2_buttons (pad2_buttons),
		.pad2_type    (pad2_type),
		.pad2_valid   (pad2_valid),
		.usb_joy1     (usb_joy1),
		.usb_joy2     (usb_joy2),
		.spin_pos     (spin_pos),
		.osd_open     (osd_open),
		.pause_on_osd (pause_on_osd),
		.rgb_in       (rgb_in),
		.inp0         (inp0),
		.inp1         (inp1),
		.inp2         (inp2),
		.dsw0         (dsw0),
		.dsw1         (dsw1),
		.h240         (h240),
		.pause        (pause),
		.rgb_out      (rgb_out),
		.osd_request  (osd_request)
	);

	//////////////////////////////////////////////////////////////////////
	// Clock and run limit
	//////////////////////////////////////////////////////////////////////

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// Limit is set from the vector count once the file is loaded
	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout after %0d cycles, the vectors did not finish", cycle_limit);
			$display("Done: errors found");
			$fatal(1, "Simulation timed out");
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	// Reads all vectors, lines starting with # are skipped
	task automatic load_golden();
		int               fd;
		int               code;
		int               nread;
		string            name;
		logic [8*128-1:0] rest;
		logic [31:0]      fld [0:24];
		fd = $fopen(GOLDEN_PATH, "r");
		if (fd == 0) begin
			$display("Cannot open the golden file %s", GOLDEN_PATH);
			$display("Done: errors found");
			$fatal(1, "Missing golden file");
		end else begin
			while (!$feof(fd)) begin
				code = $fscanf(fd, "%s", name);
				if (code == 1 && name == "#") begin
					code = $fgets(rest, fd);
				end else if (code == 1) begin
					// 16 input fields then 9 expected fields
					nread = 0;
					for (int k = 0; k < 25; k++) begin
						code = $fscanf(fd, "%h", fld[k]);
						if (code == 1) begin
							nread++;
						end
					end
					if (nread != 25) begin
						$display("Golden line %s has %0d of 25 values", name, nread);
						$display("Done: errors found");
						$fatal(1, "Bad golden file");
					end else begin
						name_q.push_back(name);
						// Inputs in port order of the top level
						stim_q.push_back({fld[0][0], fld[1][7:0], fld[2][24:0], fld[3][7:0],
							fld[4], fld[5][7:0], fld[6][0], fld[7], fld[8][7:0], fld[9][0],
							fld[10][15:0], fld[11][15:0], fld[12][7:0], fld[13][0],
							fld[14][0], fld[15][7:0]});
						exp_q.push_back({fld[16][7:0], fld[17][7:0], fld[18][7:0],
							fld[19][7:0], fld[20][7:0], fld[21][0], fld[22][0],
							fld[23][7:0], fld[24][0]});
					end
				end
			end
			$fclose(fd);
			if (name_q.size() == 0) begin
				$display("The golden file holds no vectors");
				$display("Done: errors found");
				$fatal(1, "Empty golden file");
			end
		end
	endtask

	task automatic apply_vector(input logic [STIM_W-1:0] stim);
		{load_wr, load_index, load_addr, load_data, pad1_buttons, pad1_type, pad1_valid,
			pad2_buttons, pad2_type, pad2_valid, usb_joy1, usb_joy2, spin_pos,
			osd_open, pause_on_osd, rgb_in} = stim;
	endtask

	// Stops the run at the first mismatch
	task automatic compare_value(input string test, input string field,
		input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Error: test %s, %s expected %0h actual %0h", test, field, expected,
				actual);
			$display("Done: errors found");
			$fatal(1, "Output mismatch");
		end
	endtask

	task automatic check_outputs(input string test, input logic [EXP_W-1:0] exp);
		logic [7:0] e_inp0;
		logic [7:0] e_inp1;
		logic [7:0] e_inp2;
		logic [7:0] e_dsw0;
		logic [7:0] e_dsw1;
		logic       e_h240;
		logic       e_pause;
		logic [7:0] e_rgb;
		logic       e_osd;
		{e_inp0, e_inp1, e_inp2, e_dsw0, e_dsw1, e_h240, e_pause, e_rgb, e_osd} = exp;
		compare_value(test, "inp0", e_inp0, inp0);
		compare_value(test, "inp1", e_inp1, inp1);
		compare_value(test, "inp2", e_inp2, inp2);
		compare_value(test, "dsw0", e_dsw0, dsw0);
		compare_value(test, "dsw1", e_dsw1, dsw1);
		compare_value(test, "h240", e_h240, h240);
		compare_value(test, "pause", e_pause, pause);
		compare_value(test, "rgb_out", e_rgb, rgb_out);
		compare_value(test, "osd_request", e_osd, osd_request);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		iRST = 1'b1;
		apply_vector('0);
		load_golden();
		cycle_limit = 2 * stim_q.size() + 20;
		// Two rising edges in reset
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		iRST = 1'b0;
		apply_vector(stim_q[0]);
		// Check one rising edge later, then drive the next line
		for (int i = 0; i < stim_q.size(); i++) begin
			@(negedge clk_sys);
			check_outputs(name_q[i], exp_q[i]);
			if (i + 1 < stim_q.size()) begin
				apply_vector(stim_q[i + 1]);
			end
		end
		$display("Done: no errors");
		$finish;
	end

endmodule

// File: tests/sys1_golden.txt
# name wr idx addr data pad1_btn t1 v1 pad2_btn t2 v2 usb1 usb2 spin osd pon rgb_in
# expected, all hex: inp0 inp1 inp2 dsw0 dsw1 h240 pause rgb_out osd_request
cfgmode  1 01 00 04 00000000 00 0 00000000 00 0 0000 0000 00 0 0 b6  ff ff ff 00 00 1 0 b6 0
cfgdip0  1 fe 00 a5 00000000 00 0 00000000 00 0 0000 0000 00 0 0 b6  ff ff ff a5 00 1 0 b6 0
cfgdip1  1 fe 01 3c 00000000 00 0 00000000 00 0 0000 0000 00 0 0 b6  ff ff ff a5 3c 1 0 b6 0
cfgdip5  1 fe 05 77 00000000 00 0 00000000 00 0 0000 0000 00 0 0 b6  ff ff ff a5 3c 1 0 b6 0
p1type0  0 00 00 00 00000000 00 1 00000000 00 0 0001 0002 00 0 0 b6  3f 3f ff a5 3c 1 0 b6 0
p1press  0 00 00 00 00000001 00 1 00000000 00 0 0001 0002 00 0 0 b6  3f 3f ff a5 3c 1 0 b6 0
p1seen   0 00 00 00 00000000 00 1 00000000 00 0 0001 0002 00 0 0 b6  bf bf ff a5 3c 1 0 b6 0
p1start  0 00 00 00 00000020 00 1 00000000 00 0 0001 0002 00 0 0 b6  bf bf ef a5 3c 1 0 b6 0
p2typeff 0 00 00 00 00000000 00 0 00000000 ff 1 0001 0002 00 0 0 b6  3f 3f ff a5 3c 1 0 b6 0
p2press  0 00 00 00 00000000 00 0 00000020 ff 1 0001 0002 00 0 0 b6  3f 3f ff a5 3c 1 0 b6 0
p2only   0 00 00 00 00000000 00 0 00000020 ff 1 0001 0002 00 0 0 b6  bf bf df a5 3c 1 0 b6 0
bothpads 0 00 00 00 00000000 00 1 00000000 ff 1 0001 0002 00 0 0 b6  ff ff ff a5 3c 1 0 b6 0
normal   0 00 00 00 00000000 00 0 00000000 00 0 0061 0a18 5a 0 0 b6  98 98 ee a5 3c 1 0 b6 0
setdual  1 01 00 0c 00000000 00 0 00000000 00 0 0061 0a18 5a 0 0 b6  98 98 ee a5 3c 1 0 b6 0
dual     0 00 00 00 00000000 00 0 00000000 00 0 0061 0a18 5a 0 0 b6  b4 b4 ee a5 3c 1 0 b6 0
setspin  1 01 00 2c 00000000 00 0 00000000 00 0 0061 0a18 5a 0 0 b6  b4 b4 ee a5 3c 1 0 b6 0
spinner  0 00 00 00 00000000 00 0 00000000 00 0 0061 0a18 5a 0 0 b6  a5 a5 2e a5 3c 1 0 b6 0
setnorm  1 01 00 00 00000000 00 0 00000000 00 0 0061 0a18 5a 0 0 b6  a5 a5 2e a5 3c 0 0 b6 0
pspress  0 00 00 00 00000000 00 0 00000000 00 0 1000 0000 00 0 0 b6  ff ff ff a5 3c 0 1 b6 0
pswait1  0 00 00 00 00000000 00 0 00000000 00 0 0000 0000 00 0 0 b6  ff ff ff a5 3c 0 1 b6 0
pswait2  0 00 00 00 00000000 00 0 00000000 00 0 0000 0000 00 0 0 b6  ff ff ff a5 3c 0 1 b6 0
pswait3  0 00 00 00 00000000 00 0 00000000 00 0 0000 0000 00 0 0 b6  ff ff ff a5 3c 0 1 b6 0
pswait4  0 00 00 00 00000000 00 0 00000000 00 0 0000 0000 00 0 0 b6  ff ff ff a5 3c 0 1 b6 0
pswait5  0 00 00 00 00000000 00 0 00000000 00 0 0000 0000 00 0 0 b6  ff ff ff a5 3c 0 1 b6 0
pswait6  0 00 00 00 00000000 00 0 00000000 00 0 0000 0000 00 0 0 b6  ff ff ff a5 3c 0 1 b6 0
pswait7  0 00 00 00 00000000 00 0 00000000 00 0 0000 0000 00 0 0 b6  ff ff ff a5 3c 0 1 b6 0
psdim    0 00 00 00 00000000 00 0 00000000 00 0 0000 0000 00 0 0 b6  ff ff ff a5 3c 0 1 49 0
psdimff  0 00 00 00 00000000 00 0 00000000 00 0 0000 0000 00 0 0 ff  ff ff ff a5 3c 0 1 6d 0
psagain  0 00 00 00 00000000 00 0 00000000 00 0 1000 0000 00 0 0 b6  ff ff ff a5 3c 0 0 49 0
psundim  0 00 00 00 00000000 00 0 00000000 00 0 0000 0000 00 0 0 b6  ff ff ff a5 3c 0 0 b6 0
osdpause 0 00 00 00 00000000 00 0 00000000 00 0 0000 0000 00 1 1 b6  ff ff ff a5 3c 0 1 b6 0
osdnoen  0 00 00 00 00000000 00 0 00000000 00 0 0000 0000 00 1 0 b6  ff ff ff a5 3c 0 0 b6 0
osdcombo 0 00 00 00 00000000 00 0 04000021 ff 0 0000 0000 00 0 0 b6  ff ff ff a5 3c 0 0 b6 1
osdnofst 0 00 00 00 00000000 00 0 04000020 ff 0 0000 0000 00 0 0 b6  ff ff ff a5 3c 0 0 b6 0
osdnostr 0 00 00 00 00000000 00 0 04000001 ff 0 0000 0000 00 0 0 b6  ff ff ff a5 3c 0 0 b6 0
osdnodwn 0 00 00 00 00000000 00 0 00000021 ff 0 0000 0000 00 0 0 b6  ff ff ff a5 3c 0 0 b6 0

// File: all.f
source/sys1_pkg.sv
source/sys1_config_loader.sv
source/sys1_player_select.sv
source/sys1_input_encoder.sv
source/sys1_pause_ctrl.sv
source/sys1_control_top.sv
tests/tb_sys1_control.sv

// File: Bender.yml
package:
  name: sys1_control

sources:
  - source/sys1_pkg.sv
  - source/sys1_config_loader.sv
  - source/sys1_player_select.sv
  - source/sys1_input_encoder.sv
  - source/sys1_pause_ctrl.sv
  - source/sys1_control_top.sv
  - target: test
    files:
      - tests/tb_sys1_control.sv
